// ==== design/kv_pkg.sv ====
package kv_pkg;

    // firmware port handshake states
    typedef enum logic [1:0] {
        KV_WB_IDLE    = 2'd0,
        KV_WB_RESPOND = 2'd1
    } kv_wb_state_e;

    // what a firmware word address points at
    typedef enum logic [1:0] {
        KV_REG_ENTRY_CTRL    = 2'd0,
        KV_REG_CLEAR_SECRETS = 2'd1,
        KV_REG_UNMAPPED      = 2'd2
    } kv_reg_kind_e;

    localparam int KV_DATA_W = 32;
    localparam int KV_ADDR_W = 6;

    // entries sit at word addresses 0 .. NUM_KEYS-1
    localparam logic [KV_ADDR_W-1:0] KV_CLEAR_SECRETS_ADDR = 6'd32;

    // flush patterns
    localparam logic [KV_DATA_W-1:0] KV_DEBUG_VALUE_0 = 32'haaaa_aaaa;
    localparam logic [KV_DATA_W-1:0] KV_DEBUG_VALUE_1 = 32'h5555_5555;

    // entry control word layout
    localparam int KV_CTRL_LOCK_WR_BIT    = 0;
    localparam int KV_CTRL_LOCK_USE_BIT   = 1;
    localparam int KV_CTRL_CLEAR_BIT      = 2;
    localparam int KV_CTRL_DEST_VALID_LSB = 8;
    localparam int KV_CTRL_LAST_DWORD_LSB = 16;

    // clear_secrets word layout
    localparam int KV_CLR_WR_DEBUG_BIT  = 0;
    localparam int KV_CLR_SEL_DEBUG_BIT = 1;

endpackage

// ==== design/kv_wb_regs.sv ====
`timescale 1ns/1ps

module kv_wb_regs #(
    parameter int NUM_KEYS   = 8,
    parameter int NUM_DWORDS = 4,
    parameter int NUM_READ   = 3,
    localparam int ENT_W = (NUM_KEYS > 1) ? $clog2(NUM_KEYS) : 1,
    localparam int OFS_W = (NUM_DWORDS > 1) ? $clog2(NUM_DWORDS) : 1
) (
    input  logic                            clk,
    input  logic                            rst_b,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [kv_pkg::KV_ADDR_W-1:0]    wb_adr_i,
    input  logic [kv_pkg::KV_DATA_W-1:0]    wb_dat_i,
    output logic [kv_pkg::KV_DATA_W-1:0]    wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o,
    input  logic [NUM_KEYS-1:0]             entry_lock_wr_i,
    input  logic [NUM_KEYS-1:0]             entry_lock_use_i,
    input  logic [NUM_KEYS*NUM_READ-1:0]    entry_dest_valid_i,
    input  logic [NUM_KEYS*OFS_W-1:0]       entry_last_dword_i,
    output logic [NUM_KEYS-1:0]             lock_wr_set_o,
    output logic [NUM_KEYS-1:0]             lock_use_set_o,
    output logic [NUM_KEYS-1:0]             clear_req_o,
    output logic                            flush_o,
    output logic [kv_pkg::KV_DATA_W-1:0]    flush_value_o
);

    kv_pkg::kv_wb_state_e state_q;
    kv_pkg::kv_reg_kind_e reg_kind;
    logic [ENT_W-1:0]     entry_sel;
    logic                 resp_cycle;
    logic                 wr_ctrl;
    logic                 wr_clear_secrets;
    logic                 sel_debug_q;
    logic                 sel_debug;

    always_comb begin
        if (int'(wb_adr_i) < NUM_KEYS) begin
            reg_kind = kv_pkg::KV_REG_ENTRY_CTRL;
        end else if (wb_adr_i == kv_pkg::KV_CLEAR_SECRETS_ADDR) begin
            reg_kind = kv_pkg::KV_REG_CLEAR_SECRETS;
        end else begin
            reg_kind = kv_pkg::KV_REG_UNMAPPED;
        end
    end

    assign entry_sel = wb_adr_i[ENT_W-1:0];

    // answer once, one cycle after the request shows up
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state_q <= kv_pkg::KV_WB_IDLE;
        end else begin
            case (state_q)
                kv_pkg::KV_WB_IDLE: begin
                    if (wb_cyc_i && wb_stb_i) begin
                        state_q <= kv_pkg::KV_WB_RESPOND;
                    end
                end
                default: state_q <= kv_pkg::KV_WB_IDLE;
            endcase
        end
    end

    assign resp_cycle = (state_q == kv_pkg::KV_WB_RESPOND) && wb_cyc_i && wb_stb_i;
    assign wb_ack_o   = resp_cycle && (reg_kind != kv_pkg::KV_REG_UNMAPPED);
    assign wb_err_o   = resp_cycle && (reg_kind == kv_pkg::KV_REG_UNMAPPED);

    assign wr_ctrl          = wb_ack_o && wb_we_i && (reg_kind == kv_pkg::KV_REG_ENTRY_CTRL);
    assign wr_clear_secrets = wb_ack_o && wb_we_i && (reg_kind == kv_pkg::KV_REG_CLEAR_SECRETS);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            sel_debug_q <= 1'b0;
        end else if (wr_clear_secrets) begin
            sel_debug_q <= wb_dat_i[kv_pkg::KV_CLR_SEL_DEBUG_BIT];
        end
    end

    // a flush write uses the pattern it selects in the same word
    assign sel_debug     = wr_clear_secrets ? wb_dat_i[kv_pkg::KV_CLR_SEL_DEBUG_BIT] : sel_debug_q;
    assign flush_o       = wr_clear_secrets && wb_dat_i[kv_pkg::KV_CLR_WR_DEBUG_BIT];
    assign flush_value_o = sel_debug ? kv_pkg::KV_DEBUG_VALUE_1 : kv_pkg::KV_DEBUG_VALUE_0;

    always_comb begin
        lock_wr_set_o  = '0;
        lock_use_set_o = '0;
        clear_req_o    = '0;
        if (wr_ctrl) begin
            lock_wr_set_o[entry_sel]  = wb_dat_i[kv_pkg::KV_CTRL_LOCK_WR_BIT];
            lock_use_set_o[entry_sel] = wb_dat_i[kv_pkg::KV_CTRL_LOCK_USE_BIT];
            clear_req_o[entry_sel]    = wb_dat_i[kv_pkg::KV_CTRL_CLEAR_BIT];
        end
    end

    // readback, clear reads as zero since it is only a request
    always_comb begin
        wb_dat_o = '0;
        if (wb_ack_o && !wb_we_i) begin
            if (reg_kind == kv_pkg::KV_REG_ENTRY_CTRL) begin
                wb_dat_o[kv_pkg::KV_CTRL_LOCK_WR_BIT]  = entry_lock_wr_i[entry_sel];
                wb_dat_o[kv_pkg::KV_CTRL_LOCK_USE_BIT] = entry_lock_use_i[entry_sel];
                wb_dat_o[kv_pkg::KV_CTRL_DEST_VALID_LSB +: NUM_READ] =
                    entry_dest_valid_i[entry_sel*NUM_READ +: NUM_READ];
                wb_dat_o[kv_pkg::KV_CTRL_LAST_DWORD_LSB +: OFS_W] =
                    entry_last_dword_i[entry_sel*OFS_W +: OFS_W];
            end else begin
                wb_dat_o[kv_pkg::KV_CLR_SEL_DEBUG_BIT] = sel_debug_q;
            end
        end
    end

endmodule

// ==== design/kv_write_router.sv ====
`timescale 1ns/1ps

module kv_write_router #(
    parameter int NUM_KEYS   = 8,
    parameter int NUM_DWORDS = 4,
    parameter int NUM_WRITE  = 2,
    parameter int NUM_READ   = 3,
    localparam int ENT_W = (NUM_KEYS > 1) ? $clog2(NUM_KEYS) : 1,
    localparam int OFS_W = (NUM_DWORDS > 1) ? $clog2(NUM_DWORDS) : 1,
    localparam int CNT_W = $clog2(NUM_WRITE + 1)
) (
    input  logic [NUM_WRITE-1:0]                    kv_wr_en_i,
    input  logic [NUM_WRITE*ENT_W-1:0]              kv_wr_entry_i,
    input  logic [NUM_WRITE*OFS_W-1:0]              kv_wr_offset_i,
    input  logic [NUM_WRITE*kv_pkg::KV_DATA_W-1:0]  kv_wr_data_i,
    input  logic [NUM_WRITE*NUM_READ-1:0]           kv_wr_dest_valid_i,
    input  logic [NUM_KEYS-1:0]                     entry_reject_i,
    output logic [NUM_KEYS-1:0]                     entry_hit_o,
    output logic                                    wr_multi_o,
    output logic [OFS_W-1:0]                        wr_offset_o,
    output logic [kv_pkg::KV_DATA_W-1:0]            wr_data_o,
    output logic [NUM_READ-1:0]                     wr_dest_valid_o,
    output logic [NUM_WRITE-1:0]                    kv_wr_error_o
);

    logic [CNT_W-1:0] wr_cnt;
    logic [ENT_W-1:0] wr_entry;

    // count writers and pick up the fields of the (single) one
    always_comb begin
        wr_cnt          = '0;
        wr_entry        = '0;
        wr_offset_o     = '0;
        wr_data_o       = '0;
        wr_dest_valid_o = '0;
        for (int c = 0; c < NUM_WRITE; c++) begin
            if (kv_wr_en_i[c]) begin
                wr_cnt          = wr_cnt + CNT_W'(1);
                wr_entry        = kv_wr_entry_i[c*ENT_W +: ENT_W];
                wr_offset_o     = kv_wr_offset_i[c*OFS_W +: OFS_W];
                wr_data_o       = kv_wr_data_i[c*kv_pkg::KV_DATA_W +: kv_pkg::KV_DATA_W];
                wr_dest_valid_o = kv_wr_dest_valid_i[c*NUM_READ +: NUM_READ];
            end
        end
    end

    assign wr_multi_o = wr_cnt > CNT_W'(1);

    // no entry is hit on a collision
    always_comb begin
        for (int e = 0; e < NUM_KEYS; e++) begin
            entry_hit_o[e] = (wr_cnt == CNT_W'(1)) && (wr_entry == ENT_W'(e));
        end
    end

    always_comb begin
        for (int c = 0; c < NUM_WRITE; c++) begin
            kv_wr_error_o[c] = kv_wr_en_i[c] & wr_multi_o;
            for (int e = 0; e < NUM_KEYS; e++) begin
                if (kv_wr_en_i[c] && (kv_wr_entry_i[c*ENT_W +: ENT_W] == ENT_W'(e))) begin
                    kv_wr_error_o[c] = kv_wr_error_o[c] | entry_reject_i[e];
                end
            end
        end
    end

endmodule

// ==== design/kv_entry.sv ====
`timescale 1ns/1ps

module kv_entry #(
    parameter int NUM_DWORDS = 4,
    parameter int NUM_READ   = 3,
    localparam int OFS_W = (NUM_DWORDS > 1) ? $clog2(NUM_DWORDS) : 1
) (
    input  logic                                    clk,
    input  logic                                    rst_b,
    input  logic                                    hit_i,
    input  logic                                    multi_i,
    input  logic [OFS_W-1:0]                        offset_i,
    input  logic [kv_pkg::KV_DATA_W-1:0]            data_i,
    input  logic [NUM_READ-1:0]                     dest_valid_i,
    input  logic                                    lock_wr_set_i,
    input  logic                                    lock_use_set_i,
    input  logic                                    clear_req_i,
    input  logic                                    flush_i,
    input  logic [kv_pkg::KV_DATA_W-1:0]            flush_value_i,
    output logic [NUM_DWORDS*kv_pkg::KV_DATA_W-1:0] data_o,
    output logic [NUM_READ-1:0]                     dest_valid_o,
    output logic [OFS_W-1:0]                        last_dword_o,
    output logic                                    lock_wr_o,
    output logic                                    lock_use_o,
    output logic                                    reject_o
);

    logic [NUM_DWORDS-1:0][kv_pkg::KV_DATA_W-1:0] data_q;
    logic clear_q;
    logic locked;
    logic blocked;
    logic accept;

    assign locked   = lock_wr_o | lock_use_o;
    assign blocked  = locked | clear_q;
    assign accept   = hit_i & ~blocked & ~multi_i;
    assign reject_o = blocked | multi_i;
    assign data_o   = data_q;

    // locks only go away with reset
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock_wr_o  <= 1'b0;
            lock_use_o <= 1'b0;
        end else begin
            lock_wr_o  <= lock_wr_o | lock_wr_set_i;
            lock_use_o <= lock_use_o | lock_use_set_i;
        end
    end

    // clear holds as long as a client keeps writing into it
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            clear_q <= 1'b0;
        end else begin
            clear_q <= multi_i | (clear_req_i & ~locked) | (clear_q & hit_i);
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            dest_valid_o <= '0;
            last_dword_o <= '0;
        end else if (clear_q) begin
            dest_valid_o <= '0;
            last_dword_o <= '0;
        end else if (accept) begin
            dest_valid_o <= dest_valid_i;
            last_dword_o <= offset_i;
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            data_q <= '0;
        end else if (clear_q) begin
            data_q <= '0;
        end else if (flush_i && !locked) begin
            data_q <= {NUM_DWORDS{flush_value_i}};
        end else if (accept) begin
            data_q[offset_i] <= data_i;
        end
    end

endmodule

// ==== design/kv_read_mux.sv ====
`timescale 1ns/1ps

module kv_read_mux #(
    parameter int NUM_KEYS   = 8,
    parameter int NUM_DWORDS = 4,
    parameter int NUM_READ   = 3,
    localparam int ENT_W = (NUM_KEYS > 1) ? $clog2(NUM_KEYS) : 1,
    localparam int OFS_W = (NUM_DWORDS > 1) ? $clog2(NUM_DWORDS) : 1
) (
    input  logic [NUM_READ*ENT_W-1:0]                        kv_rd_entry_i,
    input  logic [NUM_READ*OFS_W-1:0]                        kv_rd_offset_i,
    input  logic [NUM_KEYS*NUM_DWORDS*kv_pkg::KV_DATA_W-1:0] entry_data_i,
    input  logic [NUM_KEYS*NUM_READ-1:0]                     entry_dest_valid_i,
    input  logic [NUM_KEYS-1:0]                              entry_lock_use_i,
    input  logic [NUM_KEYS*OFS_W-1:0]                        entry_last_dword_i,
    output logic [NUM_READ*kv_pkg::KV_DATA_W-1:0]            kv_rd_data_o,
    output logic [NUM_READ-1:0]                              kv_rd_error_o,
    output logic [NUM_READ-1:0]                              kv_rd_last_o
);

    localparam int DW = kv_pkg::KV_DATA_W;

    always_comb begin
        kv_rd_data_o  = '0;
        kv_rd_error_o = '0;
        kv_rd_last_o  = '0;
        for (int c = 0; c < NUM_READ; c++) begin
            for (int e = 0; e < NUM_KEYS; e++) begin
                if (kv_rd_entry_i[c*ENT_W +: ENT_W] == ENT_W'(e)) begin
                    // client needs its dest_valid bit and no use lock
                    kv_rd_error_o[c] = entry_lock_use_i[e] | ~entry_dest_valid_i[e*NUM_READ + c];
                    kv_rd_last_o[c]  = kv_rd_offset_i[c*OFS_W +: OFS_W] ==
                                       entry_last_dword_i[e*OFS_W +: OFS_W];
                    for (int d = 0; d < NUM_DWORDS; d++) begin
                        if (!kv_rd_error_o[c] &&
                            (kv_rd_offset_i[c*OFS_W +: OFS_W] == OFS_W'(d))) begin
                            kv_rd_data_o[c*DW +: DW] = entry_data_i[(e*NUM_DWORDS + d)*DW +: DW];
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== design/kv_top.sv ====
`timescale 1ns/1ps

module kv_top #(
    parameter int NUM_KEYS   = 8,
    parameter int NUM_DWORDS = 4,
    parameter int NUM_WRITE  = 2,
    parameter int NUM_READ   = 3,
    localparam int ENT_W = (NUM_KEYS > 1) ? $clog2(NUM_KEYS) : 1,
    localparam int OFS_W = (NUM_DWORDS > 1) ? $clog2(NUM_DWORDS) : 1,
    localparam int DW    = kv_pkg::KV_DATA_W
) (
    input  logic                            clk,
    input  logic                            rst_b,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [kv_pkg::KV_ADDR_W-1:0]    wb_adr_i,
    input  logic [DW-1:0]                   wb_dat_i,
    output logic [DW-1:0]                   wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o,
    input  logic [NUM_WRITE-1:0]            kv_wr_en_i,
    input  logic [NUM_WRITE*ENT_W-1:0]      kv_wr_entry_i,
    input  logic [NUM_WRITE*OFS_W-1:0]      kv_wr_offset_i,
    input  logic [NUM_WRITE*DW-1:0]         kv_wr_data_i,
    input  logic [NUM_WRITE*NUM_READ-1:0]   kv_wr_dest_valid_i,
    output logic [NUM_WRITE-1:0]            kv_wr_error_o,
    input  logic [NUM_READ*ENT_W-1:0]       kv_rd_entry_i,
    input  logic [NUM_READ*OFS_W-1:0]       kv_rd_offset_i,
    output logic [NUM_READ*DW-1:0]          kv_rd_data_o,
    output logic [NUM_READ-1:0]             kv_rd_error_o,
    output logic [NUM_READ-1:0]             kv_rd_last_o
);

    logic [NUM_KEYS-1:0]               entry_hit;
    logic [NUM_KEYS-1:0]               entry_reject;
    logic                              wr_multi;
    logic [OFS_W-1:0]                  wr_offset;
    logic [DW-1:0]                     wr_data;
    logic [NUM_READ-1:0]               wr_dest_valid;
    logic [NUM_KEYS*NUM_DWORDS*DW-1:0] entry_data;
    logic [NUM_KEYS*NUM_READ-1:0]      entry_dest_valid;
    logic [NUM_KEYS*OFS_W-1:0]         entry_last_dword;
    logic [NUM_KEYS-1:0]               entry_lock_wr;
    logic [NUM_KEYS-1:0]               entry_lock_use;
    logic [NUM_KEYS-1:0]               lock_wr_set;
    logic [NUM_KEYS-1:0]               lock_use_set;
    logic [NUM_KEYS-1:0]               clear_req;
    logic                              flush;
    logic [DW-1:0]                     flush_value;

    kv_wb_regs #(
        .NUM_KEYS(NUM_KEYS),
        .NUM_DWORDS(NUM_DWORDS),
        .NUM_READ(NUM_READ)
    ) kv_wb_regs_i (
        .clk(clk),
        .rst_b(rst_b),
        .wb_cyc_i(wb_cyc_i),
        .wb_stb_i(wb_stb_i),
        .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i),
        .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o),
        .wb_ack_o(wb_ack_o),
        .wb_err_o(wb_err_o),
        .entry_lock_wr_i(entry_lock_wr),
        .entry_lock_use_i(entry_lock_use),
        .entry_dest_valid_i(entry_dest_valid),
        .entry_last_dword_i(entry_last_dword),
        .lock_wr_set_o(lock_wr_set),
        .lock_use_set_o(lock_use_set),
        .clear_req_o(clear_req),
        .flush_o(flush),
        .flush_value_o(flush_value)
    );

    kv_write_router #(
        .NUM_KEYS(NUM_KEYS),
        .NUM_DWORDS(NUM_DWORDS),
        .NUM_WRITE(NUM_WRITE),
        .NUM_READ(NUM_READ)
    ) kv_write_router_i (
        .kv_wr_en_i(kv_wr_en_i),
        .kv_wr_entry_i(kv_wr_entry_i),
        .kv_wr_offset_i(kv_wr_offset_i),
        .kv_wr_data_i(kv_wr_data_i),
        .kv_wr_dest_valid_i(kv_wr_dest_valid_i),
        .entry_reject_i(entry_reject),
        .entry_hit_o(entry_hit),
        .wr_multi_o(wr_multi),
        .wr_offset_o(wr_offset),
        .wr_data_o(wr_data),
        .wr_dest_valid_o(wr_dest_valid),
        .kv_wr_error_o(kv_wr_error_o)
    );

    for (genvar g = 0; g < NUM_KEYS; g++) begin : g_entry
        kv_entry #(
            .NUM_DWORDS(NUM_DWORDS),
            .NUM_READ(NUM_READ)
        ) kv_entry_i (
            .clk(clk),
            .rst_b(rst_b),
            .hit_i(entry_hit[g]),
            .multi_i(wr_multi),
            .offset_i(wr_offset),
            .data_i(wr_data),
            .dest_valid_i(wr_dest_valid),
            .lock_wr_set_i(lock_wr_set[g]),
            .lock_use_set_i(lock_use_set[g]),
            .clear_req_i(clear_req[g]),
            .flush_i(flush),
            .flush_value_i(flush_value),
            .data_o(entry_data[g*NUM_DWORDS*DW +: NUM_DWORDS*DW]),
            .dest_valid_o(entry_dest_valid[g*NUM_READ +: NUM_READ]),
            .last_dword_o(entry_last_dword[g*OFS_W +: OFS_W]),
            .lock_wr_o(entry_lock_wr[g]),
            .lock_use_o(entry_lock_use[g]),
            .reject_o(entry_reject[g])
        );
    end

    kv_read_mux #(
        .NUM_KEYS(NUM_KEYS),
        .NUM_DWORDS(NUM_DWORDS),
        .NUM_READ(NUM_READ)
    ) kv_read_mux_i (
        .kv_rd_entry_i(kv_rd_entry_i),
        .kv_rd_offset_i(kv_rd_offset_i),
        .entry_data_i(entry_data),
        .entry_dest_valid_i(entry_dest_valid),
        .entry_lock_use_i(entry_lock_use),
        .entry_last_dword_i(entry_last_dword),
        .kv_rd_data_o(kv_rd_data_o),
        .kv_rd_error_o(kv_rd_error_o),
        .kv_rd_last_o(kv_rd_last_o)
    );

endmodule

// ==== dv/kv_tb_model.svh ====
`ifndef KV_TB_MODEL_SVH
`define KV_TB_MODEL_SVH

// expected vault contents, kept in step with the stimulus
logic [DW-1:0]       m_data [NUM_KEYS][NUM_DWORDS];
logic [NUM_READ-1:0] m_dv [NUM_KEYS];
logic [OFS_W-1:0]    m_last [NUM_KEYS];
logic [NUM_KEYS-1:0] m_lock_wr;
logic [NUM_KEYS-1:0] m_lock_use;
logic                m_sel_debug;

task automatic model_clear(input int e);
    m_dv[e] = '0;
    m_last[e] = '0;
    for (int d = 0; d < NUM_DWORDS; d++) begin
        m_data[e][d] = '0;
    end
endtask

task automatic model_init();
    m_lock_wr = '0;
    m_lock_use = '0;
    m_sel_debug = 1'b0;
    for (int e = 0; e < NUM_KEYS; e++) begin
        model_clear(e);
    end
endtask

// clear only takes on an entry that was unlocked before this write
task automatic model_ctrl_write(input int e, input logic [DW-1:0] wdat);
    if (wdat[kv_pkg::KV_CTRL_CLEAR_BIT] && !m_lock_wr[e] && !m_lock_use[e]) begin
        model_clear(e);
    end
    m_lock_wr[e] = m_lock_wr[e] | wdat[kv_pkg::KV_CTRL_LOCK_WR_BIT];
    m_lock_use[e] = m_lock_use[e] | wdat[kv_pkg::KV_CTRL_LOCK_USE_BIT];
endtask

task automatic model_flush(input logic [DW-1:0] wdat);
    m_sel_debug = wdat[kv_pkg::KV_CLR_SEL_DEBUG_BIT];
    if (wdat[kv_pkg::KV_CLR_WR_DEBUG_BIT]) begin
        for (int e = 0; e < NUM_KEYS; e++) begin
            for (int d = 0; d < NUM_DWORDS; d++) begin
                if (!m_lock_wr[e] && !m_lock_use[e]) begin
                    m_data[e][d] = m_sel_debug ? kv_pkg::KV_DEBUG_VALUE_1
                                               : kv_pkg::KV_DEBUG_VALUE_0;
                end
            end
        end
    end
endtask

function automatic kv_pkg::kv_reg_kind_e addr_kind(input logic [AW-1:0] adr);
    if (adr < NUM_KEYS) begin
        return kv_pkg::KV_REG_ENTRY_CTRL;
    end else if (adr == kv_pkg::KV_CLEAR_SECRETS_ADDR) begin
        return kv_pkg::KV_REG_CLEAR_SECRETS;
    end
    return kv_pkg::KV_REG_UNMAPPED;
endfunction

// clear reads back as zero, it is only a request
function automatic logic [DW-1:0] expected_readback(input logic [AW-1:0] adr);
    logic [DW-1:0] w;
    int e;
    w = '0;
    e = int'(adr);
    if (adr == kv_pkg::KV_CLEAR_SECRETS_ADDR) begin
        w[kv_pkg::KV_CLR_SEL_DEBUG_BIT] = m_sel_debug;
    end else begin
        w[kv_pkg::KV_CTRL_LOCK_WR_BIT] = m_lock_wr[e];
        w[kv_pkg::KV_CTRL_LOCK_USE_BIT] = m_lock_use[e];
        w[kv_pkg::KV_CTRL_DEST_VALID_LSB +: NUM_READ] = m_dv[e];
        w[kv_pkg::KV_CTRL_LAST_DWORD_LSB +: OFS_W] = m_last[e];
    end
    return w;
endfunction

task automatic check_data(input string sig, input logic [DW-1:0] got, input logic [DW-1:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, sig, got, exp));
    end
endtask

task automatic check_flag(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, sig, got, exp));
    end
endtask

task automatic check_ctrl_word(input logic [AW-1:0] adr, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH at %0t: wb_dat_o at address %0d got %h expected %h",
                           $time, adr, got, exp));
    end
endtask

// mapped kinds answer with ack, unmapped with err
task automatic check_response(input kv_pkg::kv_reg_kind_e kind, input logic ack, input logic err);
    logic [1:0] exp_resp;
    exp_resp = (kind == kv_pkg::KV_REG_UNMAPPED) ? 2'b01 : 2'b10;
    if ({ack, err} !== exp_resp) begin
        fail_run($sformatf("MISMATCH at %0t: wb_ack_o/wb_err_o for %s got %b expected %b",
                           $time, kind.name(), {ack, err}, exp_resp));
    end
endtask

task automatic wb_xfer(input logic we, input logic [AW-1:0] adr, input logic [DW-1:0] wdat,
                       output logic ack, output logic err, output logic [DW-1:0] rdat);
    int waited;
    waited = 0;
    ack = 1'b0;
    err = 1'b0;
    rdat = '0;
    @(negedge clk);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    while (!ack && !err) begin
        @(negedge clk);
        waited++;
        ack = wb_ack_o;
        err = wb_err_o;
        rdat = wb_dat_o;
        if (!ack && !err && waited >= 4) begin
            fail_run($sformatf("Wishbone transfer to address %0d got neither ack nor err in 4 cycles",
                               adr));
        end
    end
    // the rising edge in between completes the transfer
    @(negedge clk);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
endtask

task automatic wb_read_check(input logic [AW-1:0] adr);
    logic ack;
    logic err;
    logic [DW-1:0] rdat;
    wb_xfer(1'b0, adr, '0, ack, err, rdat);
    check_response(addr_kind(adr), ack, err);
    if (ack) begin
        check_ctrl_word(adr, rdat, expected_readback(adr));
    end
endtask

task automatic wb_write(input logic [AW-1:0] adr, input logic [DW-1:0] wdat);
    logic ack;
    logic err;
    logic [DW-1:0] rdat;
    kv_pkg::kv_reg_kind_e kind;
    kind = addr_kind(adr);
    wb_xfer(1'b1, adr, wdat, ack, err, rdat);
    check_response(kind, ack, err);
    if (kind == kv_pkg::KV_REG_ENTRY_CTRL) begin
        model_ctrl_write(int'(adr), wdat);
    end else if (kind == kv_pkg::KV_REG_CLEAR_SECRETS) begin
        model_flush(wdat);
    end
endtask

`endif

// ==== dv/kv_tb.sv ====
`timescale 1ns/1ps

module kv_tb;

    localparam int NUM_KEYS   = 8;
    localparam int NUM_DWORDS = 4;
    localparam int NUM_WRITE  = 2;
    localparam int NUM_READ   = 3;
    localparam int ENT_W      = $clog2(NUM_KEYS);
    localparam int OFS_W      = $clog2(NUM_DWORDS);
    localparam int DW         = kv_pkg::KV_DATA_W;
    localparam int AW         = kv_pkg::KV_ADDR_W;
    localparam int RD_ENT_W   = NUM_READ * ENT_W;
    localparam int RD_OFS_W   = NUM_READ * OFS_W;
    localparam int CHECK_DLY  = 10;
    localparam int N_RAND     = 60;
    localparam int N_WB       = 40;
    localparam int SWEEP_CYC  = NUM_KEYS * NUM_DWORDS;
    // reset, random writes with two reads each, wishbone reads, refill, probes of cleared
    // entries and four sweeps plus roughly sixty cycles of directed transfers
    localparam int TEST_CYCLES = 10 + 4 * N_RAND + 3 * N_WB + 6 * SWEEP_CYC
                                 + (NUM_KEYS + 1) * (NUM_DWORDS + 1) + 60;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic                          clk = 1'b0;
    logic                          rst_b;
    logic                          wb_cyc_i;
    logic                          wb_stb_i;
    logic                          wb_we_i;
    logic [AW-1:0]                 wb_adr_i;
    logic [DW-1:0]                 wb_dat_i;
    logic [DW-1:0]                 wb_dat_o;
    logic                          wb_ack_o;
    logic                          wb_err_o;
    logic [NUM_WRITE-1:0]          kv_wr_en_i;
    logic [NUM_WRITE*ENT_W-1:0]    kv_wr_entry_i;
    logic [NUM_WRITE*OFS_W-1:0]    kv_wr_offset_i;
    logic [NUM_WRITE*DW-1:0]       kv_wr_data_i;
    logic [NUM_WRITE*NUM_READ-1:0] kv_wr_dest_valid_i;
    logic [NUM_WRITE-1:0]          kv_wr_error_o;
    logic [RD_ENT_W-1:0]           kv_rd_entry_i;
    logic [RD_OFS_W-1:0]           kv_rd_offset_i;
    logic [NUM_READ*DW-1:0]        kv_rd_data_o;
    logic [NUM_READ-1:0]           kv_rd_error_o;
    logic [NUM_READ-1:0]           kv_rd_last_o;
    integer                        seed;
    int                            cycles = 0;

    kv_top #(
        .NUM_KEYS(NUM_KEYS),
        .NUM_DWORDS(NUM_DWORDS),
        .NUM_WRITE(NUM_WRITE),
        .NUM_READ(NUM_READ)
    ) kv_top_i (.*);

    `include "kv_tb_model.svh"

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            fail_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // one client writes one dword and sees its combinational error flag
    task automatic write_one(input int c, input int e, input int o,
                             input logic [DW-1:0] d, input logic [NUM_READ-1:0] dv);
        logic blocked;
        blocked = m_lock_wr[e] | m_lock_use[e];
        @(negedge clk);
        kv_wr_en_i = '0;
        kv_wr_en_i[c] = 1'b1;
        kv_wr_entry_i[c*ENT_W +: ENT_W] = ENT_W'(e);
        kv_wr_offset_i[c*OFS_W +: OFS_W] = OFS_W'(o);
        kv_wr_data_i[c*DW +: DW] = d;
        kv_wr_dest_valid_i[c*NUM_READ +: NUM_READ] = dv;
        #CHECK_DLY;
        check_flag($sformatf("kv_wr_error_o[%0d]", c), kv_wr_error_o[c], blocked);
        if (!blocked) begin
            m_data[e][o] = d;
            m_dv[e] = dv;
            m_last[e] = OFS_W'(o);
        end
        @(negedge clk);
        kv_wr_en_i = '0;
    endtask

    task automatic read_check(input logic [RD_ENT_W-1:0] ents, input logic [RD_OFS_W-1:0] offs);
        int e;
        int o;
        logic err;
        @(negedge clk);
        kv_rd_entry_i = ents;
        kv_rd_offset_i = offs;
        #CHECK_DLY;
        for (int c = 0; c < NUM_READ; c++) begin
            e = int'(ents[c*ENT_W +: ENT_W]);
            o = int'(offs[c*OFS_W +: OFS_W]);
            err = m_lock_use[e] | ~m_dv[e][c];
            check_flag($sformatf("kv_rd_error_o[%0d]", c), kv_rd_error_o[c], err);
            check_flag($sformatf("kv_rd_last_o[%0d]", c), kv_rd_last_o[c],
                       OFS_W'(o) == m_last[e]);
            check_data($sformatf("kv_rd_data_o[%0d]", c), kv_rd_data_o[c*DW +: DW],
                       err ? DW'(0) : m_data[e][o]);
        end
    endtask

    task automatic sweep();
        for (int e = 0; e < NUM_KEYS; e++) begin
            for (int d = 0; d < NUM_DWORDS; d++) begin
                read_check({NUM_READ{ENT_W'(e)}}, {NUM_READ{OFS_W'(d)}});
            end
        end
    endtask

    // the other dwords of a cleared entry still read zero once dword 0 opens it to every client
    task automatic probe_cleared(input int e);
        write_one(0, e, 0, $random(seed), '1);
        for (int d = 1; d < NUM_DWORDS; d++) begin
            read_check({NUM_READ{ENT_W'(e)}}, {NUM_READ{OFS_W'(d)}});
        end
    endtask

    initial begin : stimulus
        int c;
        int e;
        int o;
        logic [AW-1:0] adr;
        seed = 32'ha63d;
        rst_b = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        kv_wr_en_i = '0;
        kv_wr_entry_i = '0;
        kv_wr_offset_i = '0;
        kv_wr_data_i = '0;
        kv_wr_dest_valid_i = '0;
        kv_rd_entry_i = '0;
        kv_rd_offset_i = '0;
        model_init();
        repeat (10) @(negedge clk);
        rst_b = 1'b1;

        // random single writes read back by every client and then by a random read
        repeat (N_RAND) begin
            c = {$random(seed)} % NUM_WRITE;
            e = {$random(seed)} % NUM_KEYS;
            o = {$random(seed)} % NUM_DWORDS;
            write_one(c, e, o, $random(seed), NUM_READ'($random(seed)));
            read_check({NUM_READ{ENT_W'(e)}}, {NUM_READ{OFS_W'(o)}});
            read_check(RD_ENT_W'($random(seed)), RD_OFS_W'($random(seed)));
        end

        // control readback where a good share of the addresses are unmapped
        repeat (N_WB) begin
            adr = AW'($random(seed));
            if (adr[4]) begin
                adr = AW'(adr % NUM_KEYS);
            end
            wb_read_check(adr);
        end
        wb_read_check(kv_pkg::KV_CLEAR_SECRETS_ADDR);

        // both clients in one cycle so nothing lands and every entry clears
        @(negedge clk);
        kv_wr_en_i = '1;
        for (c = 0; c < NUM_WRITE; c++) begin
            kv_wr_entry_i[c*ENT_W +: ENT_W] = ENT_W'($random(seed));
            kv_wr_data_i[c*DW +: DW] = $random(seed);
        end
        #CHECK_DLY;
        for (c = 0; c < NUM_WRITE; c++) begin
            check_flag($sformatf("kv_wr_error_o[%0d]", c), kv_wr_error_o[c], 1'b1);
        end
        for (e = 0; e < NUM_KEYS; e++) begin
            model_clear(e);
        end
        @(negedge clk);
        kv_wr_en_i = '0;
        repeat (2) @(negedge clk);
        sweep();
        for (e = 0; e < NUM_KEYS; e++) begin
            probe_cleared(e);
        end

        // refill every dword so the lock and flush checks see real data
        for (e = 0; e < NUM_KEYS; e++) begin
            for (o = 0; o < NUM_DWORDS; o++) begin
                write_one({$random(seed)} % NUM_WRITE, e, o, $random(seed),
                          NUM_READ'($random(seed)));
            end
        end

        // lock writes on entry 1 and use on entry 2 and show zero writes leave them locked
        wb_write(AW'(1), DW'(1) << kv_pkg::KV_CTRL_LOCK_WR_BIT);
        wb_write(AW'(2), DW'(1) << kv_pkg::KV_CTRL_LOCK_USE_BIT);
        write_one(0, 1, 0, $random(seed), '1);
        write_one(1, 2, 3, $random(seed), '1);
        wb_write(AW'(1), '0);
        wb_write(AW'(2), '0);
        wb_read_check(AW'(1));
        wb_read_check(AW'(2));

        // clear entry 3 while the locked entries ignore the request
        wb_write(AW'(3), DW'(1) << kv_pkg::KV_CTRL_CLEAR_BIT);
        wb_write(AW'(1), DW'(1) << kv_pkg::KV_CTRL_CLEAR_BIT);
        wb_write(AW'(2), DW'(1) << kv_pkg::KV_CTRL_CLEAR_BIT);
        repeat (3) @(negedge clk);
        sweep();
        wb_read_check(AW'(3));
        probe_cleared(3);

        // flush with each debug pattern
        for (c = 0; c < 2; c++) begin
            wb_write(kv_pkg::KV_CLEAR_SECRETS_ADDR, DW'({c[0], 1'b1}));
            sweep();
            wb_read_check(kv_pkg::KV_CLEAR_SECRETS_ADDR);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+dv
design/kv_pkg.sv
design/kv_wb_regs.sv
design/kv_write_router.sv
design/kv_entry.sv
design/kv_read_mux.sv
design/kv_top.sv
dv/kv_tb.sv
